// File: logic/mipsPkg.sv
//==========================================================
// mips shared definitions
// opcodes, functs, ALU ops, control and trace structs, sizes
//==========================================================
package mipsPkg;

  //==========================================================
  // memory sizes and reset state
  //==========================================================
  localparam int          memWords = 128;
  localparam int          memAddrW = 7;
  localparam logic [31:0] resetPc  = 32'h0000_0000;

  // write destination choice
  localparam logic [1:0] dstRt   = 2'd0;
  localparam logic [1:0] dstRd   = 2'd1;
  localparam logic [1:0] dstLink = 2'd2;

  //==========================================================
  // instruction encodings
  //==========================================================
  typedef enum logic [5:0] {
    rType = 6'h00,
    j     = 6'h02,
    jal   = 6'h03,
    beq   = 6'h04,
    addi  = 6'h08,
    lw    = 6'h23,
    sw    = 6'h2b
  } opcodeT;

  // R-type funct field
  typedef enum logic [5:0] {
    fJr  = 6'h08,
    fAdd = 6'h20,
    fSub = 6'h22,
    fAnd = 6'h24,
    fOr  = 6'h25,
    fSlt = 6'h2a
  } functT;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluNone
  } aluOpT;

  // next pc source
  typedef enum logic [1:0] {
    pcSeq, pcBranch, pcJump, pcReg
  } pcSelT;

  //==========================================================
  // structs
  //==========================================================
  typedef struct packed {
    logic       regWrite;
    logic [1:0] regDst;
    logic       aluSrc;
    logic       memToReg;
    logic       linkWrite;
    logic       memWrite;
    logic       branch;
    pcSelT      pcSel;
    aluOpT      aluOp;
  } ctrlT;

  // program load strobe, honoured only during reset
  typedef struct packed {
    logic                en;
    logic [memAddrW-1:0] addr;
    logic [31:0]         data;
  } progLoadT;

  // one committed instruction
  typedef struct packed {
    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         instr;
    logic                regWe;
    logic [4:0]          regAddr;
    logic [31:0]         regData;
    logic                memWe;
    logic [memAddrW-1:0] memAddr;
    logic [31:0]         memData;
  } retireT;

endpackage

// File: logic/alu.sv
//==========================================================
// 32-bit ALU
// add, sub, and, or, signed slt, zero flag
//==========================================================
`timescale 1ns/1ps

module alu import mipsPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOpT       op,
  output logic [31:0] result,
  output logic        zero
);

  logic lessThan;

  // signed compare for slt
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {31'd0, lessThan};
      // nop and unknown ops give zero
      default: result = '0;
    endcase
  end

  // core qualifies this with the branch field
  assign zero = (result == 32'd0);

endmodule

// File: logic/regFile.sv
//==========================================================
// 32 x 32 register file
// two combinational reads, one clocked write, r0 fixed
//==========================================================
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  rAddr1,
  input  logic [4:0]  rAddr2,
  input  logic [4:0]  wAddr,
  input  logic [31:0] wData,
  output logic [31:0] rData1,
  output logic [31:0] rData2
);

  logic [31:0] regs [32];

  // whole file cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != 5'd0)) begin
      regs[wAddr] <= wData;
    end
  end

  // r0 reads as zero regardless of storage
  assign rData1 = (rAddr1 == 5'd0) ? 32'd0 : regs[rAddr1];
  assign rData2 = (rAddr2 == 5'd0) ? 32'd0 : regs[rAddr2];

  // r0 storage must never be written
  regZeroHeld: assert property (@(posedge clk) disable iff (!rst) regs[0] == 32'd0);

endmodule

// File: logic/pcUnit.sv
//==========================================================
// program counter with next-pc selection
// sequential, beq, j/jal and jr targets
//==========================================================
`timescale 1ns/1ps

module pcUnit import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        run,
  input  pcSelT       pcSel,
  input  logic        taken,
  input  logic [31:0] branchOff,
  input  logic [25:0] jumpTarget,
  input  logic [31:0] regTarget,
  output logic [31:0] pc,
  output logic        running
);

  logic [31:0] pcPlus4;
  logic [31:0] branchPc;
  logic [31:0] nextPc;

  assign pcPlus4  = pc + 32'd4;
  // word offset relative to the following instruction
  assign branchPc = pcPlus4 + {branchOff[29:0], 2'b00};

  always_comb begin
    case (pcSel)
      pcBranch: nextPc = taken ? branchPc : pcPlus4;
      // upper region bits kept from pc + 4
      pcJump:   nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};
      pcReg:    nextPc = regTarget;
      default:  nextPc = pcPlus4;
    endcase
  end

  // run flag lags reset release by one cycle, pc holds until then
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      running <= 1'b0;
      pc      <= resetPc;
    end else begin
      running <= run;
      if (running) begin
        pc <= nextPc;
      end
    end
  end

  pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

// File: logic/controlUnit.sv
//==========================================================
// main decoder
// opcode and funct to control fields, ALU op included
//==========================================================
`timescale 1ns/1ps

module controlUnit import mipsPkg::*; (
  input  logic [31:0] instr,
  output ctrlT        ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    // unknown encodings fall through as a nop
    ctrl       = '0;
    ctrl.pcSel = pcSeq;
    ctrl.aluOp = aluNone;
    case (opcode)
      rType: begin
        ctrl.regDst = dstRd;
        // funct picks the ALU op, jr writes nothing
        case (funct)
          fAdd, fSub, fAnd, fOr, fSlt: ctrl.regWrite = 1'b1;
          fJr:     ctrl.pcSel = pcReg;
          default: ctrl.regWrite = 1'b0;
        endcase
        case (funct)
          fAdd:    ctrl.aluOp = aluAdd;
          fSub:    ctrl.aluOp = aluSub;
          fAnd:    ctrl.aluOp = aluAnd;
          fOr:     ctrl.aluOp = aluOr;
          fSlt:    ctrl.aluOp = aluSlt;
          default: ctrl.aluOp = aluNone;
        endcase
      end
      addi: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = dstRt;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      lw: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = dstRt;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      // address = rs + imm, data from rt
      sw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      // equality via subtract and zero flag
      beq: begin
        ctrl.branch = 1'b1;
        ctrl.pcSel  = pcBranch;
        ctrl.aluOp  = aluSub;
      end
      j: ctrl.pcSel = pcJump;
      // return address pc + 8 into r31
      jal: begin
        ctrl.regWrite  = 1'b1;
        ctrl.regDst    = dstLink;
        ctrl.linkWrite = 1'b1;
        ctrl.pcSel     = pcJump;
      end
      default: ctrl.pcSel = pcSeq;
    endcase
  end

  always_comb begin
    noStoreAndWrite: assert final (!(ctrl.memWrite && ctrl.regWrite));
  end

endmodule

// File: logic/dataMem.sv
//==========================================================
// data memory, 128 words
// async read, write on rising edge
//==========================================================
`timescale 1ns/1ps

module dataMem import mipsPkg::*; (
  input  logic                clk,
  input  logic                we,
  input  logic [memAddrW-1:0] addr,
  input  logic [31:0]         wData,
  output logic [31:0]         rData
);

  logic [31:0] mem [memWords];

  // word addressed
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wData;
    end
  end

  // same-cycle read for lw
  assign rData = mem[addr];

endmodule

// File: logic/instrMem.sv
//==========================================================
// instruction memory, 128 words
// filled through the load port, read at the pc
//==========================================================
`timescale 1ns/1ps

module instrMem import mipsPkg::*; (
  input  logic        clk,
  input  progLoadT    load,
  input  logic [31:0] addr,
  output logic [31:0] instr
);

  logic [31:0] mem [memWords];

  // program load, one word per edge
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // byte pc to word index
  assign instr = mem[addr[memAddrW+1:2]];

endmodule

// File: logic/mipsCore.sv
//==========================================================
// single-cycle MIPS core
// datapath muxing, write gating and retire trace
//==========================================================
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         instr,
  output logic [31:0]         instrAddr,
  output logic [memAddrW-1:0] dmemAddr,
  output logic                dmemWe,
  output logic [31:0]         dmemWdata,
  input  logic [31:0]         dmemRdata,
  output retireT              retire
);

  ctrlT        ctrl;
  logic [31:0] pc;
  logic        running;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [4:0]  wAddr;
  logic [31:0] wData;
  logic        regWe;

  //==========================================================
  // fetch and next pc
  //==========================================================
  pcUnit pcUnit_i (
    .clk(clk), .rst(rst), .run(1'b1), .pcSel(ctrl.pcSel),
    .taken(ctrl.branch & aluZero), .branchOff(immExt),
    .jumpTarget(instr[25:0]), .regTarget(rsData),
    .pc(pc), .running(running)
  );

  assign instrAddr = pc;

  controlUnit controlUnit_i (.instr(instr), .ctrl(ctrl));

  //==========================================================
  // operands and execute
  //==========================================================
  assign immExt = {{16{instr[15]}}, instr[15:0]};
  // immediate for addi, lw, sw
  assign aluB   = ctrl.aluSrc ? immExt : rtData;

  alu alu_i (.a(rsData), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(aluZero));

  // destination is rt, rd or r31 for jal
  always_comb begin
    case (ctrl.regDst)
      dstRd:   wAddr = instr[15:11];
      dstLink: wAddr = 5'd31;
      default: wAddr = instr[20:16];
    endcase
  end

  // write-back picks link, load data or ALU result
  assign wData = ctrl.linkWrite ? (pc + 32'd8) : (ctrl.memToReg ? dmemRdata : aluResult);
  // no write before running or to r0
  assign regWe = running && ctrl.regWrite && (wAddr != 5'd0);

  regFile regFile_i (
    .clk(clk), .rst(rst), .we(regWe),
    .rAddr1(instr[25:21]), .rAddr2(instr[20:16]), .wAddr(wAddr),
    .wData(wData), .rData1(rsData), .rData2(rtData)
  );

  // word index from the ALU result
  assign dmemAddr  = aluResult[memAddrW+1:2];
  assign dmemWe    = running && ctrl.memWrite;
  assign dmemWdata = rtData;

  //==========================================================
  // retire trace
  //==========================================================
  assign retire = '{valid: running, pc: pc, instr: instr, regWe: regWe, regAddr: wAddr,
                    regData: wData, memWe: dmemWe, memAddr: dmemAddr, memData: rtData};

endmodule

// File: logic/mipsSystem.sv
//==========================================================
// mips top level
// core with its instruction and data memories
//==========================================================
`timescale 1ns/1ps

module mipsSystem import mipsPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  progLoadT load,
  output retireT   retire
);

  logic [31:0]         instr;
  logic [31:0]         instrAddr;
  logic [memAddrW-1:0] dmemAddr;
  logic                dmemWe;
  logic [31:0]         dmemWdata;
  logic [31:0]         dmemRdata;

  mipsCore mipsCore_i (
    .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
    .dmemAddr(dmemAddr), .dmemWe(dmemWe), .dmemWdata(dmemWdata),
    .dmemRdata(dmemRdata), .retire(retire)
  );

  // program store, loaded while reset is held
  instrMem instrMem_i (.clk(clk), .load(load), .addr(instrAddr), .instr(instr));

  dataMem dataMem_i (
    .clk(clk), .we(dmemWe), .addr(dmemAddr), .wData(dmemWdata), .rData(dmemRdata)
  );

endmodule

// File: test/mipsRefModel.svh
//==========================================================
// ISA reference model for the mips testbench
// predicts pc, register and memory effects per instruction
//==========================================================
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// one predicted retire plus the pc that follows it
typedef struct packed {
  logic [31:0] pc;
  logic [31:0] instr;
  logic        regWe;
  logic [4:0]  regAddr;
  logic [31:0] regData;
  logic        memWe;
  logic [6:0]  memAddr;
  logic [31:0] memData;
  logic [31:0] nextPc;
} expectT;

logic [31:0] modelRegs [32];
logic [31:0] modelMem [128];
logic [31:0] modelPc;

// architectural effect of one instruction at pc
function automatic expectT predict(input logic [31:0] pc, input logic [31:0] ins);
  expectT      e;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] ea;
  logic [4:0]  dst;
  logic [31:0] val;
  logic        writes;
  a        = modelRegs[ins[25:21]];
  b        = modelRegs[ins[20:16]];
  imm      = {{16{ins[15]}}, ins[15:0]};
  ea       = a + imm;
  e        = '0;
  e.pc     = pc;
  e.instr  = ins;
  e.nextPc = pc + 32'd4;
  dst      = ins[20:16];
  val      = '0;
  writes   = 1'b0;
  case (ins[31:26])
    // R-type with funct in the low six bits
    6'h00: begin
      dst    = ins[15:11];
      writes = 1'b1;
      case (ins[5:0])
        6'h20: val = a + b;
        6'h22: val = a - b;
        6'h24: val = a & b;
        6'h25: val = a | b;
        // bias the sign bit so an unsigned compare orders signed values
        6'h2a: val = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
        // jr
        6'h08: begin
          writes   = 1'b0;
          e.nextPc = a;
        end
        default: writes = 1'b0;
      endcase
    end
    // addi
    6'h08: begin
      val    = ea;
      writes = 1'b1;
    end
    // lw
    6'h23: begin
      val    = modelMem[ea[8:2]];
      writes = 1'b1;
    end
    // sw
    6'h2b: begin
      e.memWe   = 1'b1;
      e.memAddr = ea[8:2];
      e.memData = b;
    end
    // beq offset counted in words from pc + 4
    6'h04: begin
      if (a == b) begin
        e.nextPc = pc + 32'd4 + (imm << 2);
      end
    end
    6'h02: e.nextPc = {e.nextPc[31:28], ins[25:0], 2'b00};
    // jal links pc + 8
    6'h03: begin
      e.nextPc = {e.nextPc[31:28], ins[25:0], 2'b00};
      dst      = 5'd31;
      val      = pc + 32'd8;
      writes   = 1'b1;
    end
    default: writes = 1'b0;
  endcase
  // a write to r0 is no write at all
  e.regWe   = writes && (dst != 5'd0);
  e.regAddr = dst;
  e.regData = val;
  return e;
endfunction

task automatic resetModel();
  for (int i = 0; i < 32; i++) begin
    modelRegs[i] = '0;
  end
  // never-written words stay unknown
  for (int i = 0; i < 128; i++) begin
    modelMem[i] = 'x;
  end
  modelPc = 32'd0;
endtask

// apply a predicted retire to the model state
task automatic commitStep(input expectT e);
  if (e.regWe) begin
    modelRegs[e.regAddr] = e.regData;
  end
  if (e.memWe) begin
    modelMem[e.memAddr] = e.memData;
  end
  modelPc = e.nextPc;
endtask

`endif

// File: test/mipsTb.sv
//==========================================================
// mips testbench
// random program, load under reset, retire trace checks
//==========================================================
`timescale 1ns/1ps

module mipsTb import mipsPkg::*; ();

  localparam int progWords   = 64;
  localparam int resetCycles = 3;
  // load and run take at most progWords cycles each plus one length of margin
  localparam int cycleLimit  = 3 * progWords + 8;

  logic        clk;
  logic        rst;
  progLoadT    load;
  retireT      retire;
  logic [31:0] prog [$];
  logic [31:0] loopPc;
  int          loopHits = 0;
  int          cycleCount = 0;

  `include "mipsRefModel.svh"

  expectT expected;

  mipsSystem mipsSystem_i (.clk(clk), .rst(rst), .load(load), .retire(retire));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //==========================================================
  // failure reporting
  //==========================================================
  task automatic stopOnFailure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic reportMismatch(input string testName, input logic [31:0] atPc,
                                input logic [31:0] expVal, input logic [31:0] actVal);
    stopOnFailure($sformatf("[FAIL] %s at pc %h: expected %h, actual %h",
                            testName, atPc, expVal, actVal));
  endtask

  //==========================================================
  // program generation
  //==========================================================
  function automatic logic [31:0] encR(input functT f, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {rType, rs, rt, rd, 5'd0, f};
  endfunction

  function automatic logic [31:0] encI(input opcodeT op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input opcodeT op, input int target);
    return {op, 26'(target)};
  endfunction

  // working set r0..r15 leaves r31 for the link
  function automatic logic [4:0] randReg();
    return 5'($urandom_range(15));
  endfunction

  function automatic logic [31:0] randomR();
    functT      f;
    logic [4:0] rd;
    logic [4:0] rs;
    logic [4:0] rt;
    case ($urandom_range(4))
      0: f = fAdd;
      1: f = fSub;
      2: f = fAnd;
      3: f = fOr;
      default: f = fSlt;
    endcase
    rd = randReg();
    rs = randReg();
    rt = randReg();
    return encR(f, rd, rs, rt);
  endfunction

  task automatic buildProgram();
    int          word;
    int          jalAt;
    logic [31:0] filler;
    // r10 counts the fillers that ran
    filler = encI(addi, 5'd10, 5'd10, 16'd1);
    for (int i = 1; i <= 8; i++) begin
      prog.push_back(encI(addi, 5'(i), randReg(), 16'($urandom)));
    end
    // r0 target
    prog.push_back(encI(addi, 5'd0, 5'd1, 16'($urandom)));
    repeat (12) prog.push_back(randomR());
    // store, disturb, reload the same word
    repeat (4) begin
      word = $urandom_range(memWords - 1);
      prog.push_back(encI(sw, randReg(), 5'd0, 16'(word * 4)));
      prog.push_back(randomR());
      prog.push_back(encI(lw, randReg(), 5'd0, 16'(word * 4)));
    end
    // beq r0,r0 always taken
    prog.push_back(encI(beq, 5'd0, 5'd0, 16'd1));
    prog.push_back(filler);
    // r9 = 1 against r0 is never taken
    prog.push_back(encI(addi, 5'd9, 5'd0, 16'd1));
    prog.push_back(encI(beq, 5'd0, 5'd9, 16'd1));
    prog.push_back(filler);
    // data dependent outcome
    prog.push_back(encI(beq, randReg(), randReg(), 16'd2));
    prog.push_back(filler);
    prog.push_back(filler);
    // call whose return at pc + 8 skips the slot after jal
    jalAt = prog.size();
    prog.push_back('0);
    prog.push_back(filler);
    repeat (4) prog.push_back(randomR());
    loopPc = 32'(prog.size() * 4);
    prog.push_back(encJ(j, prog.size()));
    // subroutine
    prog[jalAt] = encJ(jal, prog.size());
    repeat (3) prog.push_back(randomR());
    prog.push_back(encR(fJr, 5'd0, 5'd31, 5'd0));
  endtask

  //==========================================================
  // model stepping, end detection, timeout
  //==========================================================
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      stopOnFailure($sformatf("timeout: program did not reach its end loop in %0d cycles",
                              cycleLimit));
    end
    if (retire.valid) begin
      if (retire.pc == loopPc) begin
        loopHits <= loopHits + 1;
      end
      commitStep(expected);
      expected <= predict(modelPc, prog[modelPc[31:2]]);
    end
  end

  //==========================================================
  // checks
  //==========================================================
  // first edge performs the reset itself
  validLowInReset: assert property (@(posedge clk) (!rst && cycleCount > 0) |-> !retire.valid)
    else stopOnFailure("retire.valid was high while reset was held");
  validLowAfterRelease: assert property (@(posedge clk) $rose(rst) |-> !retire.valid)
    else stopOnFailure("retire.valid was high in the first cycle after reset release");
  firstPcZero: assert property (@(posedge clk) $rose(retire.valid) |-> retire.pc == 32'd0)
    else reportMismatch("reset pc", $sampled(retire.pc), 32'd0, $sampled(retire.pc));

  // pc covers branch, jump and return targets
  pcMatch: assert property (@(posedge clk) retire.valid |-> retire.pc == expected.pc)
    else reportMismatch("pc", $sampled(retire.pc), $sampled(expected.pc),
                        $sampled(retire.pc));
  instrMatch: assert property (@(posedge clk)
                               retire.valid |-> retire.instr == expected.instr)
    else reportMismatch("instr", $sampled(retire.pc), $sampled(expected.instr),
                        $sampled(retire.instr));
  regWeMatch: assert property (@(posedge clk) retire.valid |-> retire.regWe == expected.regWe)
    else reportMismatch("regWe", $sampled(retire.pc), $sampled(expected.regWe),
                        $sampled(retire.regWe));
  regAddrMatch: assert property (@(posedge clk) retire.valid && expected.regWe
                                 |-> retire.regAddr == expected.regAddr)
    else reportMismatch("regAddr", $sampled(retire.pc), $sampled(expected.regAddr),
                        $sampled(retire.regAddr));
  regDataMatch: assert property (@(posedge clk) retire.valid && expected.regWe
                                 |-> retire.regData == expected.regData)
    else reportMismatch("regData", $sampled(retire.pc), $sampled(expected.regData),
                        $sampled(retire.regData));
  memWeMatch: assert property (@(posedge clk) retire.valid |-> retire.memWe == expected.memWe)
    else reportMismatch("memWe", $sampled(retire.pc), $sampled(expected.memWe),
                        $sampled(retire.memWe));
  memAddrMatch: assert property (@(posedge clk) retire.valid && expected.memWe
                                 |-> retire.memAddr == expected.memAddr)
    else reportMismatch("memAddr", $sampled(retire.pc), $sampled(expected.memAddr),
                        $sampled(retire.memAddr));
  memDataMatch: assert property (@(posedge clk) retire.valid && expected.memWe
                                 |-> retire.memData == expected.memData)
    else reportMismatch("memData", $sampled(retire.pc), $sampled(expected.memData),
                        $sampled(retire.memData));

  //==========================================================
  // stimulus
  //==========================================================
  initial begin
    rst  = 1'b0;
    load = '0;
    void'($urandom(32'h0f36_c124));
    buildProgram();
    resetModel();
    expected = predict(modelPc, prog[0]);
    @(posedge clk);
    // one word per edge while reset is held
    for (int i = 0; i < prog.size(); i++) begin
      load <= '{en: 1'b1, addr: memAddrW'(i), data: prog[i]};
      @(posedge clk);
    end
    load <= '0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
    // end loop seen twice
    wait (loopHits >= 2);
    @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: mips.f
+incdir+test
logic/mipsPkg.sv
logic/alu.sv
logic/regFile.sv
logic/pcUnit.sv
logic/controlUnit.sv
logic/dataMem.sv
logic/instrMem.sv
logic/mipsCore.sv
logic/mipsSystem.sv
test/mipsTb.sv

// File: Bender.yml
package:
  name: mips

sources:
  - logic/mipsPkg.sv
  - logic/alu.sv
  - logic/regFile.sv
  - logic/pcUnit.sv
  - logic/controlUnit.sv
  - logic/dataMem.sv
  - logic/instrMem.sv
  - logic/mipsCore.sv
  - logic/mipsSystem.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/mipsTb.sv
